// ==== hw/powerIsaPkg.sv ====
package powerIsaPkg;

    // POWER numbers bits from the MSB and the word keeps that order
    typedef logic [0:31] instrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [4:0]  xoT;       // A-form extended opcode in bits 26 to 30
    typedef logic [4:0]  regIdxT;

    localparam opcodeT OpcodeInt      = 6'd31;
    localparam opcodeT OpcodeFpDouble = 6'd63;
    localparam opcodeT OpcodeFpSingle = 6'd59;

    localparam xoT XoIsel    = 5'd15;   // Opcode 31 only
    localparam xoT XoFdiv    = 5'd18;
    localparam xoT XoFsub    = 5'd20;
    localparam xoT XoFadd    = 5'd21;
    localparam xoT XoFsqrt   = 5'd22;
    localparam xoT XoFsel    = 5'd23;   // Double only
    localparam xoT XoFre     = 5'd24;
    localparam xoT XoFmul    = 5'd25;
    localparam xoT XoFrsqrte = 5'd26;
    localparam xoT XoFmsub   = 5'd28;
    localparam xoT XoFmadd   = 5'd29;
    localparam xoT XoFnmsub  = 5'd30;
    localparam xoT XoFnmadd  = 5'd31;

    // Register fields in instruction order with the record bit last
    typedef struct packed {
        regIdxT rt;
        regIdxT ra;
        regIdxT rb;
        regIdxT rc;
        logic   rc1;
    } aFormFieldsT;

endpackage

// ==== hw/decodePkg.sv ====
package decodePkg;

    typedef logic [63:0] addrT;
    typedef logic [63:0] majIdT;    // Program order tag
    typedef logic [19:0] pidT;
    typedef logic [15:0] tidT;

    // Travels unchanged alongside the instruction
    typedef struct packed {
        addrT  address;
        majIdT majId;
        pidT   pid;
        tidT   tid;
    } instHeaderT;

    // Codes line up with the backend unit IDs
    typedef enum logic [2:0] {
        FuInt   = 3'd0,
        FuFloat = 3'd1,
        FuCond  = 3'd3
    } funcUnitT;

    typedef enum logic [1:0] {
        AccNone  = 2'b00,
        AccWrite = 2'b01,
        AccRead  = 2'b10
    } accessT;

    typedef struct packed {
        logic   isReg;
        accessT access;
    } operandT;

    typedef struct packed {
        operandT rt;
        operandT ra;
        operandT rb;
        operandT rc;
    } operandSetT;

    // Grouped by which source operands are read
    typedef enum logic [2:0] {
        ClsIsel,
        ClsTwoAB,
        ClsTwoAC,
        ClsOneB,
        ClsThree
    } opClassT;

endpackage

// ==== hw/aFormFieldSplit.sv ====
`timescale 1ns/10ps

module aFormFieldSplit (
    input  logic                    clock_i,
    input  logic                    rstN_i,
    input  logic                    stall_i,
    input  logic                    enable_i,
    input  powerIsaPkg::instrT      instr_i,
    input  decodePkg::instHeaderT   header_i,
    output logic                    valid_o,
    output powerIsaPkg::opcodeT     opcode_o,
    output powerIsaPkg::xoT         xo_o,
    output powerIsaPkg::aFormFieldsT fields_o,
    output decodePkg::instHeaderT   header_o
);

    typedef struct packed {
        powerIsaPkg::opcodeT      opcode;
        powerIsaPkg::xoT          xo;
        powerIsaPkg::aFormFieldsT fields;
        decodePkg::instHeaderT    header;
    } splitRecT;

    logic     validQ;
    splitRecT recD;
    splitRecT recQ;

    always_comb begin
        recD.opcode     = instr_i[0:5];
        recD.xo         = instr_i[26:30];
        recD.fields.rt  = instr_i[6:10];
        recD.fields.ra  = instr_i[11:15];
        recD.fields.rb  = instr_i[16:20];
        recD.fields.rc  = instr_i[21:25];
        recD.fields.rc1 = instr_i[31];     // Record bit
        recD.header     = header_i;
    end

    always_ff @(posedge clock_i or negedge rstN_i) begin
        if (!rstN_i) begin
            validQ <= 1'b0;
        end else if (!stall_i) begin
            validQ <= enable_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            recQ <= recD;                  // Captured even when idle
        end
    end

    assign valid_o  = validQ;
    assign opcode_o = recQ.opcode;
    assign xo_o     = recQ.xo;
    assign fields_o = recQ.fields;
    assign header_o = recQ.header;

endmodule

// ==== hw/aFormOpDecode.sv ====
`timescale 1ns/10ps

module aFormOpDecode #(
    parameter bit SingleEnable = 1'b1
) (
    input  logic                     clock_i,
    input  logic                     rstN_i,
    input  logic                     stall_i,
    input  logic                     valid_i,
    input  powerIsaPkg::opcodeT      opcode_i,
    input  powerIsaPkg::xoT          xo_i,
    input  powerIsaPkg::aFormFieldsT fields_i,
    input  decodePkg::instHeaderT    header_i,
    output logic                     valid_o,
    output decodePkg::opClassT       opClass_o,
    output decodePkg::funcUnitT      unit_o,
    output logic                     isSingle_o,
    output logic                     raIsZero_o,
    output powerIsaPkg::aFormFieldsT fields_o,
    output decodePkg::instHeaderT    header_o
);

    typedef struct packed {
        decodePkg::opClassT       opClass;
        decodePkg::funcUnitT      unit;
        logic                     isSingle;
        logic                     raIsZero;
        powerIsaPkg::aFormFieldsT fields;
        decodePkg::instHeaderT    header;
    } decodeRecT;

    logic               fpKnown;
    decodePkg::opClassT fpClass;
    logic               known;
    logic               validQ;
    decodeRecT          recD;
    decodeRecT          recQ;

    // Floating XO table shared by opcodes 59 and 63
    always_comb begin
        fpKnown = 1'b1;
        fpClass = decodePkg::ClsTwoAB;
        case (xo_i)
            powerIsaPkg::XoFdiv,
            powerIsaPkg::XoFsub,
            powerIsaPkg::XoFadd:    fpClass = decodePkg::ClsTwoAB;
            powerIsaPkg::XoFmul:    fpClass = decodePkg::ClsTwoAC;
            powerIsaPkg::XoFsqrt,
            powerIsaPkg::XoFre,
            powerIsaPkg::XoFrsqrte: fpClass = decodePkg::ClsOneB;
            powerIsaPkg::XoFsel,
            powerIsaPkg::XoFmsub,
            powerIsaPkg::XoFmadd,
            powerIsaPkg::XoFnmsub,
            powerIsaPkg::XoFnmadd:  fpClass = decodePkg::ClsThree;
            default:                fpKnown = 1'b0;
        endcase
    end

    always_comb begin
        known         = 1'b0;
        recD.opClass  = fpClass;
        recD.unit     = decodePkg::FuFloat;
        recD.isSingle = (opcode_i == powerIsaPkg::OpcodeFpSingle);
        recD.raIsZero = (fields_i.ra == '0);
        recD.fields   = fields_i;
        recD.header   = header_i;
        case (opcode_i)
            powerIsaPkg::OpcodeInt: begin
                known        = (xo_i == powerIsaPkg::XoIsel);
                recD.opClass = decodePkg::ClsIsel;
                recD.unit    = decodePkg::FuCond;     // Isel goes to the CR unit
            end
            powerIsaPkg::OpcodeFpDouble: known = fpKnown;
            powerIsaPkg::OpcodeFpSingle: begin
                // No single-precision select in the A-form set
                known = SingleEnable && fpKnown && (xo_i != powerIsaPkg::XoFsel);
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clock_i or negedge rstN_i) begin
        if (!rstN_i) begin
            validQ <= 1'b0;
        end else if (!stall_i) begin
            validQ <= valid_i && known;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            recQ <= recD;
        end
    end

    assign valid_o    = validQ;
    assign opClass_o  = recQ.opClass;
    assign unit_o     = recQ.unit;
    assign isSingle_o = recQ.isSingle;
    assign raIsZero_o = recQ.raIsZero;
    assign fields_o   = recQ.fields;
    assign header_o   = recQ.header;

endmodule

// ==== hw/aFormOperandMap.sv ====
`timescale 1ns/10ps

module aFormOperandMap (
    input  logic                     clock_i,
    input  logic                     rstN_i,
    input  logic                     stall_i,
    input  logic                     valid_i,
    input  decodePkg::opClassT       opClass_i,
    input  decodePkg::funcUnitT      unit_i,
    input  logic                     isSingle_i,
    input  logic                     raIsZero_i,
    input  powerIsaPkg::aFormFieldsT fields_i,
    input  decodePkg::instHeaderT    header_i,
    output logic                     valid_o,
    output decodePkg::funcUnitT      unit_o,
    output logic                     isSingle_o,
    output decodePkg::operandSetT    operands_o,
    output powerIsaPkg::aFormFieldsT fields_o,
    output decodePkg::instHeaderT    header_o
);

    typedef struct packed {
        decodePkg::funcUnitT      unit;
        logic                     isSingle;
        decodePkg::operandSetT    operands;
        powerIsaPkg::aFormFieldsT fields;
        decodePkg::instHeaderT    header;
    } outRecT;

    localparam decodePkg::operandT OpUsed   = '{isReg: 1'b1, access: decodePkg::AccRead};
    localparam decodePkg::operandT OpUnused = '{isReg: 1'b0, access: decodePkg::AccNone};
    localparam decodePkg::operandT OpDest   = '{isReg: 1'b1, access: decodePkg::AccWrite};

    logic   validQ;
    outRecT recD;
    outRecT recQ;

    always_comb begin
        recD.unit        = unit_i;
        recD.isSingle    = isSingle_i;
        recD.fields      = fields_i;
        recD.header      = header_i;
        recD.operands.rt = OpDest;
        recD.operands.ra = OpUsed;
        recD.operands.rb = OpUsed;
        recD.operands.rc = OpUsed;
        case (opClass_i)
            decodePkg::ClsIsel: begin
                // RA of zero reads as the constant 0 and is still a read
                recD.operands.ra.isReg = !raIsZero_i;
                recD.operands.rc       = OpUnused;
            end
            decodePkg::ClsTwoAB: recD.operands.rc = OpUnused;
            decodePkg::ClsTwoAC: recD.operands.rb = OpUnused;
            decodePkg::ClsOneB: begin
                recD.operands.ra = OpUnused;
                recD.operands.rc = OpUnused;
            end
            default: ;                     // ClsThree reads all three
        endcase
    end

    always_ff @(posedge clock_i or negedge rstN_i) begin
        if (!rstN_i) begin
            validQ <= 1'b0;
        end else if (!stall_i) begin
            validQ <= valid_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            recQ <= recD;
        end
    end

    assign valid_o    = validQ;
    assign unit_o     = recQ.unit;
    assign isSingle_o = recQ.isSingle;
    assign operands_o = recQ.operands;
    assign fields_o   = recQ.fields;
    assign header_o   = recQ.header;

endmodule

// ==== hw/aFormDecoder.sv ====
`timescale 1ns/10ps

module aFormDecoder #(
    parameter bit SingleEnable = 1'b1     // 0 rejects opcode 59
) (
    input  logic                     clock_i,
    input  logic                     rstN_i,
    input  logic                     enable_i,
    input  logic                     stall_i,
    input  powerIsaPkg::instrT       instr_i,
    input  decodePkg::instHeaderT    header_i,
    output logic                     valid_o,
    output decodePkg::funcUnitT      unit_o,
    output logic                     isSingle_o,
    output decodePkg::operandSetT    operands_o,
    output powerIsaPkg::aFormFieldsT fields_o,
    output decodePkg::instHeaderT    header_o
);

    // Split to decode
    logic                     fsValid;
    powerIsaPkg::opcodeT      fsOpcode;
    powerIsaPkg::xoT          fsXo;
    powerIsaPkg::aFormFieldsT fsFields;
    decodePkg::instHeaderT    fsHeader;

    // Decode to operand map
    logic                     odValid;
    decodePkg::opClassT       odOpClass;
    decodePkg::funcUnitT      odUnit;
    logic                     odIsSingle;
    logic                     odRaIsZero;
    powerIsaPkg::aFormFieldsT odFields;
    decodePkg::instHeaderT    odHeader;

    aFormFieldSplit uFieldSplit (
        .clock_i  (clock_i),
        .rstN_i   (rstN_i),
        .stall_i  (stall_i),
        .enable_i (enable_i),
        .instr_i  (instr_i),
        .header_i (header_i),
        .valid_o  (fsValid),
        .opcode_o (fsOpcode),
        .xo_o     (fsXo),
        .fields_o (fsFields),
        .header_o (fsHeader)
    );

    aFormOpDecode #(
        .SingleEnable (SingleEnable)
    ) uOpDecode (
        .clock_i    (clock_i),
        .rstN_i     (rstN_i),
        .stall_i    (stall_i),
        .valid_i    (fsValid),
        .opcode_i   (fsOpcode),
        .xo_i       (fsXo),
        .fields_i   (fsFields),
        .header_i   (fsHeader),
        .valid_o    (odValid),
        .opClass_o  (odOpClass),
        .unit_o     (odUnit),
        .isSingle_o (odIsSingle),
        .raIsZero_o (odRaIsZero),
        .fields_o   (odFields),
        .header_o   (odHeader)
    );

    aFormOperandMap uOperandMap (
        .clock_i    (clock_i),
        .rstN_i     (rstN_i),
        .stall_i    (stall_i),
        .valid_i    (odValid),
        .opClass_i  (odOpClass),
        .unit_i     (odUnit),
        .isSingle_i (odIsSingle),
        .raIsZero_i (odRaIsZero),
        .fields_i   (odFields),
        .header_i   (odHeader),
        .valid_o    (valid_o),
        .unit_o     (unit_o),
        .isSingle_o (isSingle_o),
        .operands_o (operands_o),
        .fields_o   (fields_o),
        .header_o   (header_o)
    );

endmodule

// ==== dv/aFormDecoderTb.sv ====
`timescale 1ns/10ps

module aFormDecoderTb;

    localparam bit SingleOn = 1'b1;

    typedef struct {
        string                    name;
        logic                     enable;
        logic                     stall;
        logic                     tracked;      // Counted until it leaves the pipe
        powerIsaPkg::instrT       instr;
        decodePkg::instHeaderT    header;
        logic                     expValid;
        decodePkg::funcUnitT      expUnit;
        logic                     expSingle;
        decodePkg::operandSetT    expOps;
        powerIsaPkg::aFormFieldsT expFields;
    } rowT;

    logic                     clock_i;
    logic                     rstN_i;
    logic                     enable_i;
    logic                     stall_i;
    powerIsaPkg::instrT       instr_i;
    decodePkg::instHeaderT    header_i;
    logic                     valid_o;
    decodePkg::funcUnitT      unit_o;
    logic                     isSingle_o;
    decodePkg::operandSetT    operands_o;
    powerIsaPkg::aFormFieldsT fields_o;
    decodePkg::instHeaderT    header_o;

    rowT  stimRows[$];
    rowT  pipe[3];                              // Expected value for each stage
    logic comparePending = 1'b0;
    int   inFlight       = 0;
    int   checkCount     = 0;
    int   valueErrors    = 0;
    int   timeoutErrors  = 0;

    aFormDecoder #(.SingleEnable(SingleOn)) uut (.*);

    always #10 clock_i = ~clock_i;

    task automatic checkValid(input string name, input string what, input logic exp,
                              input logic act);
        checkCount++;
        if (act !== exp) begin
            valueErrors++;
            $display("[ERROR] %s %s: expected %0b, actual %0b", name, what, exp, act);
        end
    endtask

    task automatic checkUnit(input string name, input decodePkg::funcUnitT exp,
                             input decodePkg::funcUnitT act);
        checkCount++;
        if (act !== exp) begin
            valueErrors++;
            $display("[ERROR] %s unit: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkOperands(input string name, input decodePkg::operandSetT exp,
                                 input decodePkg::operandSetT act);
        checkCount++;
        if (act !== exp) begin
            valueErrors++;
            $display("[ERROR] %s operands: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkFields(input string name, input powerIsaPkg::aFormFieldsT exp,
                               input powerIsaPkg::aFormFieldsT act);
        checkCount++;
        if (act !== exp) begin
            valueErrors++;
            $display("[ERROR] %s fields: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkHeader(input string name, input decodePkg::instHeaderT exp,
                               input decodePkg::instHeaderT act);
        checkCount++;
        if (act !== exp) begin
            valueErrors++;
            $display("[ERROR] %s header: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic decodePkg::operandT operandFor(input logic used);
        decodePkg::operandT op;
        op.isReg  = used;
        op.access = used ? decodePkg::AccRead : decodePkg::AccNone;
        return op;
    endfunction

    // Reference decode straight from the A-form operand rules
    function automatic void predict(input powerIsaPkg::opcodeT op, input powerIsaPkg::xoT xo,
                                    inout rowT row);
        logic fpOk;
        logic twoAB;
        logic twoAC;
        logic oneB;
        logic three;
        fpOk  = (op == 6'd63) || (op == 6'd59 && SingleOn);
        twoAB = fpOk && (xo inside {5'd18, 5'd20, 5'd21});
        twoAC = fpOk && (xo == 5'd25);
        oneB  = fpOk && (xo inside {5'd22, 5'd24, 5'd26});
        three = fpOk && ((xo inside {[5'd28:5'd31]}) || (xo == 5'd23 && op == 6'd63));
        row.expValid  = twoAB || twoAC || oneB || three;
        row.expUnit   = decodePkg::FuFloat;
        row.expSingle = (op == 6'd59);
        row.expOps.rt = '{isReg: 1'b1, access: decodePkg::AccWrite};
        row.expOps.ra = operandFor(twoAB || twoAC || three);
        row.expOps.rb = operandFor(twoAB || oneB || three);
        row.expOps.rc = operandFor(twoAC || three);
        if (op == 6'd31 && xo == 5'd15) begin
            row.expValid        = 1'b1;
            row.expUnit         = decodePkg::FuCond;
            row.expOps.ra       = operandFor(1'b1);
            row.expOps.ra.isReg = (row.expFields.ra != 5'd0);   // Zero RA is a constant
            row.expOps.rb       = operandFor(1'b1);
        end
    endfunction

    function automatic decodePkg::instHeaderT randomHeader();
        decodePkg::instHeaderT h;
        h.address = {$urandom, $urandom};
        h.majId   = {$urandom, $urandom};
        h.pid     = 20'($urandom);
        h.tid     = 16'($urandom);
        return h;
    endfunction

    function automatic rowT idleEntry(input string name, input logic tracked);
        rowT row;
        row.name     = name;
        row.enable   = 1'b0;
        row.stall    = 1'b0;
        row.tracked  = tracked;
        row.instr    = $urandom;                // Junk word that is never accepted
        row.header   = randomHeader();
        row.expValid = 1'b0;
        return row;
    endfunction

    // Enable stays high under stall with a real fadd word
    task automatic insertStall();
        rowT row;
        row        = idleEntry("stall", 1'b0);
        row.stall  = 1'b1;
        row.enable = 1'b1;
        row.instr  = {6'd63, 20'($urandom), 5'd21, 1'b0};
        stimRows.push_back(row);
    endtask

    task automatic addRow(input powerIsaPkg::opcodeT op, input powerIsaPkg::xoT xo,
                          input powerIsaPkg::regIdxT ra);
        rowT row;
        row.name         = $sformatf("op%0d_xo%0d_ra%0d", op, xo, ra);
        row.enable       = 1'b1;
        row.stall        = 1'b0;
        row.tracked      = 1'b1;
        row.header       = randomHeader();
        row.expFields.rt = 5'($urandom);
        row.expFields.ra = ra;
        row.expFields.rb = 5'($urandom);
        row.expFields.rc = 5'($urandom);
        row.expFields.rc1 = 1'($urandom);
        row.instr = {op, row.expFields.rt, ra, row.expFields.rb, row.expFields.rc, xo,
                     row.expFields.rc1};
        predict(op, xo, row);
        stimRows.push_back(row);
        if ($urandom_range(3) == 0) begin
            insertStall();
        end
    endtask

    task automatic buildTable();
        stimRows.push_back(idleEntry("idleStart0", 1'b1));
        stimRows.push_back(idleEntry("idleStart1", 1'b1));
        insertStall();
        for (int xo = 16; xo < 32; xo++) begin
            addRow(6'd63, 5'(xo), 5'($urandom));
            addRow(6'd59, 5'(xo), 5'($urandom));
        end
        addRow(6'd31, 5'd15, 5'd7);             // Isel with a register RA
        addRow(6'd31, 5'd15, 5'd0);
        stimRows.push_back(idleEntry("idleMid", 1'b1));
        addRow(6'd31, 5'd14, 5'd3);
        addRow(6'd31, 5'd23, 5'd3);
        addRow(6'd0, 5'd21, 5'd3);
        addRow(6'd62, 5'd21, 5'd3);
    endtask

    task automatic compareOutputs();
        rowT exp;
        exp = pipe[2];
        checkValid(exp.name, "valid", exp.expValid, valid_o);
        if (exp.expValid) begin
            checkUnit(exp.name, exp.expUnit, unit_o);
            checkValid(exp.name, "isSingle", exp.expSingle, isSingle_o);
            checkOperands(exp.name, exp.expOps, operands_o);
            checkFields(exp.name, exp.expFields, fields_o);
            checkHeader(exp.name, exp.header, header_o);
        end
        if (exp.tracked) begin
            inFlight--;
        end
    endtask

    // Drive on the falling edge and check what the last open edge produced
    task automatic stepCycle(input rowT row);
        @(negedge clock_i);
        if (comparePending) begin
            compareOutputs();
        end
        enable_i = row.enable;
        stall_i  = row.stall;
        instr_i  = row.instr;
        header_i = row.header;
        @(posedge clock_i);
        comparePending = !row.stall;
        if (!row.stall) begin
            pipe[2] = pipe[1];
            pipe[1] = pipe[0];
            pipe[0] = row;
            if (row.tracked) begin
                inFlight++;
            end
        end
    endtask

    task automatic waitResetDone();
        int cycles;
        cycles = 0;
        while (valid_o !== 1'b0 && cycles < 4) begin
            @(negedge clock_i);
            cycles++;
        end
        if (valid_o !== 1'b0) begin
            timeoutErrors++;
            $display("Timeout: valid_o did not settle low after reset");
        end
    endtask

    task automatic drainPipe();
        int cycles;
        cycles = 0;
        while (inFlight > 0 && cycles < 10) begin
            stepCycle(idleEntry("drain", 1'b0));
            cycles++;
        end
        if (inFlight > 0) begin
            timeoutErrors++;
            $display("Timeout: %0d instructions never left the pipeline", inFlight);
        end
    endtask

    initial begin
        void'($urandom(32'hd980));
        clock_i  = 1'b0;
        rstN_i   = 1'b0;
        enable_i = 1'b0;
        stall_i  = 1'b0;
        instr_i  = '0;
        header_i = '0;
        for (int i = 0; i < 3; i++) begin
            pipe[i] = idleEntry("resetBubble", 1'b0);
        end
        buildTable();
        repeat (8) @(posedge clock_i);
        @(negedge clock_i);
        rstN_i = 1'b1;
        waitResetDone();
        foreach (stimRows[i]) begin
            stepCycle(stimRows[i]);
        end
        drainPipe();
        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 checkCount, valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0 && checkCount > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== aFormDecoder.f ====
hw/powerIsaPkg.sv
hw/decodePkg.sv
hw/aFormFieldSplit.sv
hw/aFormOpDecode.sv
hw/aFormOperandMap.sv
hw/aFormDecoder.sv
dv/aFormDecoderTb.sv

// ==== Bender.yml ====
package:
  name: a_form_decoder

sources:
  - hw/powerIsaPkg.sv
  - hw/decodePkg.sv
  - hw/aFormFieldSplit.sv
  - hw/aFormOpDecode.sv
  - hw/aFormOperandMap.sv
  - hw/aFormDecoder.sv
  - target: test
    files:
      - dv/aFormDecoderTb.sv
